//--- verilog/mcu_pkg.sv
// shared sizes, domain indices and interrupt bit positions
// power sequencer state type

`default_nettype none

package mcu_pkg;

  localparam int unsigned NUM_BANKS    = 2;
  localparam int unsigned NUM_DOMAINS  = NUM_BANKS + 2;
  localparam int unsigned NUM_GPIO_AO  = 8;
  localparam int unsigned NEXT_INT     = 4;
  localparam int unsigned NUM_FAST_INT = 16;
  localparam int unsigned IRQ_WIDTH    = 32;

  // domain slots in the power vectors
  localparam int unsigned DOM_CPU       = 0;
  localparam int unsigned DOM_PERIPH    = 1;
  localparam int unsigned DOM_BANK_BASE = 2;

  // core interrupt vector layout
  localparam int unsigned IRQ_SOFT_BIT  = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXT_BIT   = 11;
  localparam int unsigned IRQ_FAST_BASE = 16;

  // fast interrupt positions, timers 1..3 take 0..2
  localparam int unsigned FAST_TIMER1     = 0;
  localparam int unsigned FAST_DMA_DONE   = 3;
  localparam int unsigned FAST_SPI        = 4;
  localparam int unsigned FAST_SPI_FLASH  = 5;
  localparam int unsigned FAST_GPIO_BASE  = 6;
  localparam int unsigned FAST_DMA_WINDOW = 14;
  localparam int unsigned FAST_EXT_PERIPH = 15;

  typedef enum logic [3:0] {
    PWR_ON,
    PWR_GATE_CLK,
    PWR_ISOLATE,
    PWR_HOLD_RST,
    PWR_SWITCH_OFF,
    PWR_OFF,
    PWR_SWITCH_ON,
    PWR_RELEASE_RST,
    PWR_RELEASE_ISO
  } pwr_state_e;

endpackage

`default_nettype wire

//--- verilog/pwr_ctrl_if.sv
// power-control bundle of one domain, all active low
// modports for the sequencer and the domain side

`default_nettype none

interface pwr_ctrl_if;

  logic switch_n;
  logic switch_ack_n;
  logic iso_n;
  logic rst_n;
  logic clkgate_en_n;
  logic retentive_n;

  modport ctrl(
    output switch_n, iso_n, rst_n, clkgate_en_n, retentive_n,
    input  switch_ack_n
  );

  modport domain(
    input  switch_n, iso_n, rst_n, clkgate_en_n, retentive_n,
    output switch_ack_n
  );

endinterface

`default_nettype wire

//--- verilog/power_domain_fsm.sv
// power sequencer for a single domain
// switched or retentive power-down, outputs decoded from state

`default_nettype none

module power_domain_fsm #(
  parameter bit RETENTIVE = 1'b0
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       off_req_i,
  pwr_ctrl_if.ctrl   pwr
);

  import mcu_pkg::*;

  pwr_state_e state_q;
  pwr_state_e state_d;
  logic       ack_match;
  logic       power_down;

  // switch cells report back with variable latency
  assign ack_match = (pwr.switch_ack_n == pwr.switch_n);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      PWR_ON: begin
        if (off_req_i) begin
          state_d = PWR_GATE_CLK;
        end
      end
      PWR_GATE_CLK:   state_d = PWR_ISOLATE;
      PWR_ISOLATE:    state_d = PWR_HOLD_RST;
      PWR_HOLD_RST:   state_d = PWR_SWITCH_OFF;
      PWR_SWITCH_OFF: begin
        if (RETENTIVE || ack_match) begin
          state_d = PWR_OFF;
        end
      end
      PWR_OFF: begin
        if (!off_req_i) begin
          state_d = PWR_SWITCH_ON;
        end
      end
      PWR_SWITCH_ON: begin
        if (RETENTIVE || ack_match) begin
          state_d = PWR_RELEASE_RST;
        end
      end
      PWR_RELEASE_RST: state_d = PWR_RELEASE_ISO;
      PWR_RELEASE_ISO: state_d = PWR_ON;
      default:         state_d = PWR_ON;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= PWR_ON;
    end else begin
      state_q <= state_d;
    end
  end

  assign power_down = (state_q inside {PWR_SWITCH_OFF, PWR_OFF});

  // banks keep their switch closed and drop into retention instead
  assign pwr.switch_n     = RETENTIVE ? 1'b1 : !power_down;
  assign pwr.retentive_n  = RETENTIVE ? !power_down : 1'b1;
  assign pwr.clkgate_en_n = (state_q == PWR_ON);
  assign pwr.iso_n        = (state_q inside {PWR_ON, PWR_GATE_CLK, PWR_RELEASE_ISO});
  assign pwr.rst_n        = (state_q inside {PWR_ON, PWR_GATE_CLK, PWR_ISOLATE,
                                             PWR_RELEASE_RST, PWR_RELEASE_ISO});

  // domain is fenced off whenever its supply or retention is active
  a_iso_while_down: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (!pwr.switch_n || !pwr.retentive_n) |-> (!pwr.iso_n && !pwr.rst_n && !pwr.clkgate_en_n)
  );

  // a switch wait is only left after the acknowledge caught up
  a_ack_before_leave: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ((state_q != $past(state_q)) &&
     ($past(state_q) inside {PWR_SWITCH_OFF, PWR_SWITCH_ON}))
    |-> (RETENTIVE || ($past(pwr.switch_ack_n) == $past(pwr.switch_n)))
  );

endmodule

`default_nettype wire

//--- verilog/power_manager.sv
// cpu, peripheral and memory bank sequencers with their off requests
// debug reset merge and flattening onto per-domain vectors

`default_nettype none

module power_manager (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic                           core_sleep_i,
  input  logic                           cpu_pwr_off_en_i,
  input  logic                           periph_sleep_i,
  input  logic [mcu_pkg::NUM_BANKS-1:0]   mem_bank_sleep_i,
  input  logic                           irq_pending_i,
  input  logic                           ndmreset_ni,
  input  logic [mcu_pkg::NUM_DOMAINS-1:0] pd_switch_ack_ni,
  output logic [mcu_pkg::NUM_DOMAINS-1:0] pd_switch_no,
  output logic [mcu_pkg::NUM_DOMAINS-1:0] pd_iso_no,
  output logic [mcu_pkg::NUM_DOMAINS-1:0] pd_rst_no,
  output logic [mcu_pkg::NUM_DOMAINS-1:0] pd_clkgate_en_no,
  output logic [mcu_pkg::NUM_BANKS-1:0]   mem_retentive_no
);

  import mcu_pkg::*;

  logic [NUM_DOMAINS-1:0] off_req;

  pwr_ctrl_if pwr_if [NUM_DOMAINS] ();

  // cpu may only sleep when nothing is pending, a pending irq wakes it
  assign off_req[DOM_CPU]    = core_sleep_i && cpu_pwr_off_en_i && !irq_pending_i;
  assign off_req[DOM_PERIPH] = periph_sleep_i;

  power_domain_fsm #(
    .RETENTIVE(1'b0)
  ) i_cpu_fsm (
    .clk_i,
    .arst_n_i,
    .off_req_i(off_req[DOM_CPU]),
    .pwr      (pwr_if[DOM_CPU])
  );

  power_domain_fsm #(
    .RETENTIVE(1'b0)
  ) i_periph_fsm (
    .clk_i,
    .arst_n_i,
    .off_req_i(off_req[DOM_PERIPH]),
    .pwr      (pwr_if[DOM_PERIPH])
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    assign off_req[DOM_BANK_BASE+b] = mem_bank_sleep_i[b];

    power_domain_fsm #(
      .RETENTIVE(1'b1)
    ) i_bank_fsm (
      .clk_i,
      .arst_n_i,
      .off_req_i(off_req[DOM_BANK_BASE+b]),
      .pwr      (pwr_if[DOM_BANK_BASE+b])
    );

    assign mem_retentive_no[b] = pwr_if[DOM_BANK_BASE+b].retentive_n;
  end

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_flat
    assign pwr_if[d].switch_ack_n = pd_switch_ack_ni[d];
    assign pd_switch_no[d]        = pwr_if[d].switch_n;
    assign pd_iso_no[d]           = pwr_if[d].iso_n;
    assign pd_clkgate_en_no[d]    = pwr_if[d].clkgate_en_n;
    // debug reset hits every domain without delay
    assign pd_rst_no[d]           = pwr_if[d].rst_n && ndmreset_ni;
  end

  // a running cpu stays up while an interrupt is pending
  a_no_sleep_on_irq: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (irq_pending_i && (i_cpu_fsm.state_q == PWR_ON)) |=> (i_cpu_fsm.state_q == PWR_ON)
  );

endmodule

`default_nettype wire

//--- verilog/irq_collector.sv
// core interrupt vector assembly in the standard bit layout
// sticky fast interrupts with software clear pulses

`default_nettype none

module irq_collector (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            soft_irq_i,
  input  logic [3:0]                      timer_intr_i,
  input  logic [mcu_pkg::NEXT_INT-1:0]     ext_intr_i,
  input  logic                            dma_done_intr_i,
  input  logic                            dma_window_intr_i,
  input  logic                            spi_intr_i,
  input  logic                            spi_flash_intr_i,
  input  logic                            ext_periph_intr_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0]  gpio_intr_i,
  input  logic [mcu_pkg::NUM_FAST_INT-1:0] fast_clear_i,
  output logic [mcu_pkg::IRQ_WIDTH-1:0]    irq_o,
  output logic                            irq_pending_o
);

  import mcu_pkg::*;

  logic [NUM_FAST_INT-1:0] fast_src;
  logic [NUM_FAST_INT-1:0] fast_pend;
  logic [IRQ_WIDTH-1:0]    irq_d;
  logic [IRQ_WIDTH-1:0]    irq_q;

  always_comb begin
    fast_src                                  = '0;
    fast_src[FAST_TIMER1 +: 3]                = timer_intr_i[3:1];
    fast_src[FAST_DMA_DONE]                   = dma_done_intr_i;
    fast_src[FAST_SPI]                        = spi_intr_i;
    fast_src[FAST_SPI_FLASH]                  = spi_flash_intr_i;
    fast_src[FAST_GPIO_BASE +: NUM_GPIO_AO]   = gpio_intr_i;
    fast_src[FAST_DMA_WINDOW]                 = dma_window_intr_i;
    fast_src[FAST_EXT_PERIPH]                 = ext_periph_intr_i;
  end

  // the fast field of the output register is the pending state
  assign fast_pend = irq_q[IRQ_FAST_BASE +: NUM_FAST_INT];

  always_comb begin
    irq_d                                = '0;
    irq_d[IRQ_SOFT_BIT]                  = soft_irq_i;
    irq_d[IRQ_TIMER_BIT]                 = timer_intr_i[0];
    irq_d[IRQ_EXT_BIT]                   = |ext_intr_i;
    // set beats clear
    irq_d[IRQ_FAST_BASE +: NUM_FAST_INT] = fast_src | (fast_pend & ~fast_clear_i);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q <= '0;
    end else begin
      irq_q <= irq_d;
    end
  end

  assign irq_o         = irq_q;
  assign irq_pending_o = |irq_q;

  a_fast_sticky: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    1'b1 |=> (($past(fast_src) & ~fast_pend) == '0)
  );

endmodule

`default_nettype wire

//--- verilog/ao_gpio.sv
// always-on gpio input synchronizer
// enabled rising edges become single-cycle interrupt pulses

`default_nettype none

module ao_gpio (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_ao_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_intr_en_i,
  output logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_ao_in_o,
  output logic [mcu_pkg::NUM_GPIO_AO-1:0] gpio_intr_o
);

  import mcu_pkg::*;

  logic [NUM_GPIO_AO-1:0] meta_q;
  logic [NUM_GPIO_AO-1:0] sync_q;
  logic [NUM_GPIO_AO-1:0] prev_q;
  logic [NUM_GPIO_AO-1:0] rise;
  logic [NUM_GPIO_AO-1:0] intr_q;

  // two flops per pin, pads are asynchronous
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      meta_q <= gpio_ao_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
    end
  end

  assign rise = sync_q & ~prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      intr_q <= '0;
    end else begin
      intr_q <= rise & gpio_intr_en_i;
    end
  end

  assign gpio_ao_in_o = sync_q;
  assign gpio_intr_o  = intr_q;

endmodule

`default_nettype wire

//--- verilog/mcu_ao_top.sv
// always-on control island top level
// gpio, interrupt collector and power manager on plain ports

`default_nettype none

module mcu_ao_top (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // power control
  input  logic                            core_sleep_i,
  input  logic                            cpu_pwr_off_en_i,
  input  logic                            periph_sleep_i,
  input  logic [mcu_pkg::NUM_BANKS-1:0]    mem_bank_sleep_i,
  input  logic                            ndmreset_ni,
  input  logic [mcu_pkg::NUM_DOMAINS-1:0]  pd_switch_ack_ni,
  output logic [mcu_pkg::NUM_DOMAINS-1:0]  pd_switch_no,
  output logic [mcu_pkg::NUM_DOMAINS-1:0]  pd_iso_no,
  output logic [mcu_pkg::NUM_DOMAINS-1:0]  pd_rst_no,
  output logic [mcu_pkg::NUM_DOMAINS-1:0]  pd_clkgate_en_no,
  output logic [mcu_pkg::NUM_BANKS-1:0]    mem_retentive_no,
  // interrupt sources
  input  logic                            soft_irq_i,
  input  logic [3:0]                      timer_intr_i,
  input  logic [mcu_pkg::NEXT_INT-1:0]     ext_intr_i,
  input  logic                            dma_done_intr_i,
  input  logic                            dma_window_intr_i,
  input  logic                            spi_intr_i,
  input  logic                            spi_flash_intr_i,
  input  logic                            ext_periph_intr_i,
  input  logic [mcu_pkg::NUM_FAST_INT-1:0] fast_clear_i,
  output logic [mcu_pkg::IRQ_WIDTH-1:0]    irq_o,
  // always-on gpio
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0]  gpio_ao_i,
  input  logic [mcu_pkg::NUM_GPIO_AO-1:0]  gpio_intr_en_i,
  output logic [mcu_pkg::NUM_GPIO_AO-1:0]  gpio_ao_in_o
);

  import mcu_pkg::*;

  logic                   irq_pending;
  logic [NUM_GPIO_AO-1:0] gpio_intr;

  ao_gpio i_ao_gpio (
    .clk_i,
    .arst_n_i,
    .gpio_ao_i,
    .gpio_intr_en_i,
    .gpio_ao_in_o,
    .gpio_intr_o   (gpio_intr)
  );

  irq_collector i_irq_collector (
    .clk_i,
    .arst_n_i,
    .soft_irq_i,
    .timer_intr_i,
    .ext_intr_i,
    .dma_done_intr_i,
    .dma_window_intr_i,
    .spi_intr_i,
    .spi_flash_intr_i,
    .ext_periph_intr_i,
    .gpio_intr_i      (gpio_intr),
    .fast_clear_i,
    .irq_o,
    .irq_pending_o    (irq_pending)
  );

  power_manager i_power_manager (
    .clk_i,
    .arst_n_i,
    .core_sleep_i,
    .cpu_pwr_off_en_i,
    .periph_sleep_i,
    .mem_bank_sleep_i,
    .irq_pending_i    (irq_pending),
    .ndmreset_ni,
    .pd_switch_ack_ni,
    .pd_switch_no,
    .pd_iso_no,
    .pd_rst_no,
    .pd_clkgate_en_no,
    .mem_retentive_no
  );

endmodule

`default_nettype wire

//--- tb/tb_mcu_ao_top.sv
// testbench for the always-on control island
// step table with expected values, switch acknowledge model, verdict

`default_nettype none

module tb_mcu_ao_top;

  timeunit 1ns;
  timeprecision 1ps;

  import mcu_pkg::*;

  localparam int WAIT_LIMIT = 200;
  localparam int ACK_MAX    = 8;
  localparam int GPIO_PIN   = 5;

  localparam logic [31:0] TIMER_IRQ = 32'(1) << IRQ_TIMER_BIT;
  localparam logic [31:0] GPIO_IRQ  = 32'(1) << (IRQ_FAST_BASE + FAST_GPIO_BASE + GPIO_PIN);

  typedef enum int {DRV, PLS, WT, CHK, IDL} step_kind_e;
  typedef enum int {P_NONE, P_PSLP, P_BANK, P_CSLP, P_OFFEN, P_TMR, P_GEN, P_GPIO, P_CLR,
                    P_NDM} in_sel_e;
  typedef enum int {O_NONE, O_PWR, O_RET, O_IRQ, O_GIN} out_sel_e;

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    core_sleep_i;
  logic                    cpu_pwr_off_en_i;
  logic                    periph_sleep_i;
  logic [NUM_BANKS-1:0]    mem_bank_sleep_i;
  logic                    ndmreset_ni;
  logic [NUM_DOMAINS-1:0]  pd_switch_ack_ni;
  logic [NUM_DOMAINS-1:0]  pd_switch_no;
  logic [NUM_DOMAINS-1:0]  pd_iso_no;
  logic [NUM_DOMAINS-1:0]  pd_rst_no;
  logic [NUM_DOMAINS-1:0]  pd_clkgate_en_no;
  logic [NUM_BANKS-1:0]    mem_retentive_no;
  logic                    soft_irq_i;
  logic [3:0]              timer_intr_i;
  logic [NEXT_INT-1:0]     ext_intr_i;
  logic                    dma_done_intr_i;
  logic                    dma_window_intr_i;
  logic                    spi_intr_i;
  logic                    spi_flash_intr_i;
  logic                    ext_periph_intr_i;
  logic [NUM_FAST_INT-1:0] fast_clear_i;
  logic [IRQ_WIDTH-1:0]    irq_o;
  logic [NUM_GPIO_AO-1:0]  gpio_ao_i;
  logic [NUM_GPIO_AO-1:0]  gpio_intr_en_i;
  logic [NUM_GPIO_AO-1:0]  gpio_ao_in_o;

  string       step_name[$];
  step_kind_e  step_kind[$];
  in_sel_e     step_port[$];
  int          step_idx[$];
  logic        step_val[$];
  out_sel_e    step_obs[$];
  logic [31:0] step_exp[$];

  int seed          = 69;
  int error_count   = 0;
  int timeout_count = 0;
  int ack_left [NUM_DOMAINS] = '{default: -1};

  mcu_ao_top i_mcu_ao_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // switch cells answer 1 to ACK_MAX cycles after a change
  initial begin
    pd_switch_ack_ni = '1;
    forever begin
      @(posedge clk_i);
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        if (pd_switch_ack_ni[d] == pd_switch_no[d]) begin
          ack_left[d] = -1;
        end else begin
          if (ack_left[d] < 0) begin
            ack_left[d] = $unsigned($random(seed)) % ACK_MAX;
          end
          if (ack_left[d] == 0) begin
            pd_switch_ack_ni[d] <= pd_switch_no[d];
          end else begin
            ack_left[d]--;
          end
        end
      end
    end
  end

  function automatic void add_step(input string name, input step_kind_e kind,
                                   input in_sel_e port, input int idx, input logic val,
                                   input out_sel_e obs, input logic [31:0] exp);
    step_name.push_back(name);
    step_kind.push_back(kind);
    step_port.push_back(port);
    step_idx.push_back(idx);
    step_val.push_back(val);
    step_obs.push_back(obs);
    step_exp.push_back(exp);
  endfunction

  // power view nibbles in order switch, iso, rst, clkgate
  // bit d of each nibble is domain d
  function automatic logic [31:0] observe(input out_sel_e obs);
    case (obs)
      O_PWR:   return 32'({pd_switch_no, pd_iso_no, pd_rst_no, pd_clkgate_en_no});
      O_RET:   return 32'(mem_retentive_no);
      O_IRQ:   return irq_o;
      O_GIN:   return 32'(gpio_ao_in_o);
      default: return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic drive_input(input in_sel_e port, input int idx, input logic val);
    @(posedge clk_i);
    case (port)
      P_PSLP:  periph_sleep_i <= val;
      P_BANK:  mem_bank_sleep_i[idx] <= val;
      P_CSLP:  core_sleep_i <= val;
      P_OFFEN: cpu_pwr_off_en_i <= val;
      P_TMR:   timer_intr_i[idx] <= val;
      P_GEN:   gpio_intr_en_i[idx] <= val;
      P_GPIO:  gpio_ao_i[idx] <= val;
      P_CLR:   fast_clear_i[idx] <= val;
      P_NDM:   ndmreset_ni <= val;
      default: ;
    endcase
  endtask

  task automatic wait_for(input string name, input out_sel_e obs, input logic [31:0] exp);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while ((observe(obs) !== exp) && (cycles < WAIT_LIMIT));
    if (observe(obs) !== exp) begin
      $display("timeout in %s: output still %h instead of %h after %0d cycles",
               name, observe(obs), exp, WAIT_LIMIT);
      timeout_count++;
    end
  endtask

  function automatic void build_table();
    add_step("reset pwr",       CHK, P_NONE,  0, 0, O_PWR,  32'hffff);
    add_step("reset retention", CHK, P_NONE,  0, 0, O_RET,  32'h3);
    add_step("reset irq",       CHK, P_NONE,  0, 0, O_IRQ,  32'h0);
    // all four peripheral controls low once its switch opens
    add_step("periph sleep",    DRV, P_PSLP,  0, 1, O_NONE, 0);
    add_step("periph off",      WT,  P_NONE,  0, 0, O_PWR,  32'hdddd);
    add_step("periph wake",     DRV, P_PSLP,  0, 0, O_NONE, 0);
    add_step("periph on",       WT,  P_NONE,  0, 0, O_PWR,  32'hffff);
    // bank 0 keeps its switch closed
    add_step("bank0 sleep",     DRV, P_BANK,  0, 1, O_NONE, 0);
    add_step("bank0 retained",  WT,  P_NONE,  0, 0, O_RET,  32'h2);
    add_step("bank0 switch",    CHK, P_NONE,  0, 0, O_PWR,  32'hfbbb);
    add_step("bank0 wake",      DRV, P_BANK,  0, 0, O_NONE, 0);
    add_step("bank0 restored",  WT,  P_NONE,  0, 0, O_RET,  32'h3);
    add_step("bank0 on",        WT,  P_NONE,  0, 0, O_PWR,  32'hffff);
    // cpu sleep and timer wake
    add_step("cpu off enable",  DRV, P_OFFEN, 0, 1, O_NONE, 0);
    add_step("core sleep",      DRV, P_CSLP,  0, 1, O_NONE, 0);
    add_step("cpu off",         WT,  P_NONE,  0, 0, O_PWR,  32'heeee);
    add_step("timer irq",       DRV, P_TMR,   0, 1, O_NONE, 0);
    add_step("timer bit",       WT,  P_NONE,  0, 0, O_IRQ,  TIMER_IRQ);
    add_step("cpu woken",       WT,  P_NONE,  0, 0, O_PWR,  32'hffff);
    add_step("core awake",      DRV, P_CSLP,  0, 0, O_NONE, 0);
    add_step("cpu off disable", DRV, P_OFFEN, 0, 0, O_NONE, 0);
    add_step("timer idle",      DRV, P_TMR,   0, 0, O_NONE, 0);
    add_step("timer cleared",   WT,  P_NONE,  0, 0, O_IRQ,  32'h0);
    // gpio edge into a sticky fast interrupt
    add_step("gpio enable",     DRV, P_GEN,   GPIO_PIN, 1, O_NONE, 0);
    add_step("gpio rise",       DRV, P_GPIO,  GPIO_PIN, 1, O_NONE, 0);
    add_step("gpio synced",     WT,  P_NONE,  0, 0, O_GIN,  32'(1) << GPIO_PIN);
    add_step("gpio irq",        WT,  P_NONE,  0, 0, O_IRQ,  GPIO_IRQ);
    add_step("gpio fall",       DRV, P_GPIO,  GPIO_PIN, 0, O_NONE, 0);
    add_step("gpio hold",       IDL, P_NONE,  4, 0, O_NONE, 0);
    add_step("gpio sticky",     CHK, P_NONE,  0, 0, O_IRQ,  GPIO_IRQ);
    add_step("gpio clear",      PLS, P_CLR,   FAST_GPIO_BASE + GPIO_PIN, 1, O_NONE, 0);
    add_step("gpio cleared",    WT,  P_NONE,  0, 0, O_IRQ,  32'h0);
    // debug reset pulls every domain reset but no switch
    add_step("ndmreset on",     DRV, P_NDM,   0, 0, O_NONE, 0);
    add_step("ndmreset held",   WT,  P_NONE,  0, 0, O_PWR,  32'hff0f);
    add_step("ndmreset off",    DRV, P_NDM,   0, 1, O_NONE, 0);
    add_step("ndmreset gone",   WT,  P_NONE,  0, 0, O_PWR,  32'hffff);
  endfunction

  initial begin
    arst_n_i          = 1'b0;
    core_sleep_i      = 1'b0;
    cpu_pwr_off_en_i  = 1'b0;
    periph_sleep_i    = 1'b0;
    mem_bank_sleep_i  = '0;
    ndmreset_ni       = 1'b1;
    soft_irq_i        = 1'b0;
    timer_intr_i      = '0;
    ext_intr_i        = '0;
    dma_done_intr_i   = 1'b0;
    dma_window_intr_i = 1'b0;
    spi_intr_i        = 1'b0;
    spi_flash_intr_i  = 1'b0;
    ext_periph_intr_i = 1'b0;
    fast_clear_i      = '0;
    gpio_ao_i         = '0;
    gpio_intr_en_i    = '0;
    build_table();
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    foreach (step_name[i]) begin
      case (step_kind[i])
        DRV: drive_input(step_port[i], step_idx[i], step_val[i]);
        PLS: begin
          drive_input(step_port[i], step_idx[i], 1'b1);
          drive_input(step_port[i], step_idx[i], 1'b0);
        end
        WT:  wait_for(step_name[i], step_obs[i], step_exp[i]);
        CHK: check_value(step_name[i], step_exp[i], observe(step_obs[i]));
        IDL: repeat (step_idx[i]) @(negedge clk_i);
        default: ;
      endcase
    end
    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
verilog/mcu_pkg.sv
verilog/pwr_ctrl_if.sv
verilog/power_domain_fsm.sv
verilog/power_manager.sv
verilog/irq_collector.sv
verilog/ao_gpio.sv
verilog/mcu_ao_top.sv
tb/tb_mcu_ao_top.sv

//--- Bender.yml
package:
  name: mcu_ao

sources:
  - verilog/mcu_pkg.sv
  - verilog/pwr_ctrl_if.sv
  - verilog/power_domain_fsm.sv
  - verilog/power_manager.sv
  - verilog/irq_collector.sv
  - verilog/ao_gpio.sv
  - verilog/mcu_ao_top.sv
  - target: test
    files:
      - tb/tb_mcu_ao_top.sv
